//--- Makefile
# Verilator build and run for the Fibonacci display pipeline
# rerun without zero blanking:  make SUPPRESS_ZEROS=0

VERILATOR      ?= verilator
TOP            ?= fib_display_tb
FILELIST       ?= verilog.f
SUPPRESS_ZEROS ?= 1
BUILD_DIR      ?= obj_dir_sz$(SUPPRESS_ZEROS)
LOG            ?= sim_sz$(SUPPRESS_ZEROS).log
VFLAGS         ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS     ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSUPPRESS_ZEROS=$(SUPPRESS_ZEROS) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir_sz* sim_sz*.log

//--- hw/bcd_char_serializer.sv
// BCD to ASCII character serializer
// sends four digit characters and a newline per word, one beat per cycle,
// with optional blanking of leading zeros; last marks the newline

`timescale 1ns/10ps

module bcd_char_serializer
#(
    parameter bit SUPPRESS_ZEROS = 1'b1
)
(
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    output logic                o_ready,
    input  fib_pkg::bcd_word_t  i_word,
    output logic                o_valid,
    input  logic                i_ready,
    output fib_pkg::char_beat_t o_beat
);
    import fib_pkg::*;

    localparam int BEAT_W = $clog2(BCD_DIGITS + 1);
    localparam int POS_W  = $clog2(BCD_DIGITS);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BCD_DIGITS);

    logic                  r_busy;
    logic [BEAT_W-1:0]     r_beat;
    bcd_word_t             r_word;
    logic [POS_W-1:0]      w_pos;
    logic [BCD_DIGITS-1:0] w_lead_zero;
    logic                  w_blank;
    logic                  w_is_last;

    assign o_ready = ~r_busy;
    assign o_valid = r_busy;

    // beat 0 shows the most significant digit
    assign w_pos     = POS_W'(BCD_DIGITS - 1) - r_beat[POS_W-1:0];
    assign w_is_last = (r_beat == LAST_BEAT);

    // w_lead_zero[i] is set when digit i and all digits above it are zero
    always_comb
    begin
        w_lead_zero[BCD_DIGITS-1] = (r_word.digits[BCD_DIGITS-1] == 4'd0);
        for (int i = BCD_DIGITS - 2; i >= 0; i--)
            w_lead_zero[i] = w_lead_zero[i+1] & (r_word.digits[i] == 4'd0);
    end

    // units digit always printed
    assign w_blank = SUPPRESS_ZEROS && (w_pos != '0) && w_lead_zero[w_pos];

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            r_busy <= 1'b0;
            r_beat <= '0;
        end
        else if (!r_busy)
        begin
            if (i_valid)
            begin
                r_busy <= 1'b1;
                r_beat <= '0;
            end
        end
        else if (i_ready)
        begin
            if (w_is_last)
                r_busy <= 1'b0;
            else
                r_beat <= r_beat + 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid && o_ready)
            r_word <= i_word;
    end

    always_comb
    begin
        o_beat.tag  = r_word.tag;
        o_beat.last = w_is_last;
        if (w_is_last)
            o_beat.ascii = 8'h0A;
        else if (w_blank)
            o_beat.ascii = 8'h20;
        else
            o_beat.ascii = 8'h30 + {4'h0, r_word.digits[w_pos]};
    end

endmodule

//--- hw/bin_to_bcd.sv
// Binary to BCD converter
// iterative shift-and-add-3 (double dabble) over a 14-bit term, one load
// cycle and one shift per bit, giving four decimal digits with the tag
// inputs above 9999 give undefined digits

`timescale 1ns/10ps

module bin_to_bcd
(
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_valid,
    output logic               o_ready,
    input  fib_pkg::fib_term_t i_term,
    output logic               o_valid,
    input  logic               i_ready,
    output fib_pkg::bcd_word_t o_word
);
    import fib_pkg::*;

    localparam int CNT_W = $clog2(FIB_VALUE_W);

    typedef enum logic [1:0] {e_ready, e_operation, e_done} t_state;

    t_state                     r_state;
    t_state                     w_state_next;
    logic [CNT_W-1:0]           r_count;
    logic [CNT_W-1:0]           w_count_next;
    logic [FIB_VALUE_W-1:0]     r_bin;
    logic [FIB_VALUE_W-1:0]     w_bin_next;
    logic [BCD_DIGITS-1:0][3:0] r_digits;
    logic [BCD_DIGITS-1:0][3:0] w_digits_next;
    logic [BCD_DIGITS-1:0][3:0] w_digits_adj;
    logic [FIB_TAG_W-1:0]       r_tag;
    logic [FIB_TAG_W-1:0]       w_tag_next;

    // add 3 to any digit that would pass 9 after doubling
    always_comb
    begin
        for (int i = 0; i < BCD_DIGITS; i++)
            w_digits_adj[i] = (r_digits[i] > 4'd4) ? r_digits[i] + 4'd3 : r_digits[i];
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_ready;
            r_count <= '0;
        end
        else
        begin
            r_state <= w_state_next;
            r_count <= w_count_next;
        end
    end

    always_ff @(posedge i_clk)
    begin
        r_bin    <= w_bin_next;
        r_digits <= w_digits_next;
        r_tag    <= w_tag_next;
    end

    always_comb
    begin
        w_state_next  = r_state;
        w_count_next  = r_count;
        w_bin_next    = r_bin;
        w_digits_next = r_digits;
        w_tag_next    = r_tag;
        o_ready       = 1'b0;
        o_valid       = 1'b0;

        case (r_state)
            e_ready:
            begin
                o_ready = 1'b1;
                if (i_valid)
                begin
                    w_bin_next    = i_term.value;
                    w_digits_next = '0;
                    w_tag_next    = i_term.tag;
                    w_count_next  = CNT_W'(FIB_VALUE_W - 1);
                    w_state_next  = e_operation;
                end
            end
            e_operation:
            begin
                // top bit of the thousands digit is never set for valid input
                w_digits_next = {w_digits_adj[BCD_DIGITS-1][2:0],
                                 w_digits_adj[BCD_DIGITS-2:0],
                                 r_bin[FIB_VALUE_W-1]};
                w_bin_next    = {r_bin[FIB_VALUE_W-2:0], 1'b0};
                if (r_count == '0)
                    w_state_next = e_done;
                else
                    w_count_next = r_count - 1'b1;
            end
            e_done:
            begin
                o_valid = 1'b1;
                if (i_ready)
                    w_state_next = e_ready;
            end
            default: w_state_next = e_ready;
        endcase
    end

    assign o_word.tag    = r_tag;
    assign o_word.digits = r_digits;

endmodule

//--- hw/fib_display_top.sv
// Fibonacci term display pipeline
// request stream in, ASCII line per term out: sequencer, skid buffer,
// BCD converter, skid buffer, character serializer

`timescale 1ns/10ps

module fib_display_top
#(
    parameter bit SUPPRESS_ZEROS = 1'b1
)
(
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_req_valid,
    output logic                o_req_ready,
    input  fib_pkg::fib_req_t   i_req,
    output logic                o_char_valid,
    input  logic                i_char_ready,
    output fib_pkg::char_beat_t o_char
);
    import fib_pkg::*;

    // sequencer to skid A
    logic      seq_valid;
    logic      seq_ready;
    fib_term_t seq_term;

    // skid A to converter
    logic      conv_in_valid;
    logic      conv_in_ready;
    fib_term_t conv_in_term;

    // converter to skid B
    logic      conv_out_valid;
    logic      conv_out_ready;
    bcd_word_t conv_out_word;

    // skid B to serializer
    logic      ser_valid;
    logic      ser_ready;
    bcd_word_t ser_word;

    fib_sequencer u_sequencer (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .i_req        (i_req),
        .o_term_valid (seq_valid),
        .i_term_ready (seq_ready),
        .o_term       (seq_term)
    );

    stream_skid #(.T(fib_term_t)) u_skid_term (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (seq_valid),
        .o_ready (seq_ready),
        .i_data  (seq_term),
        .o_valid (conv_in_valid),
        .i_ready (conv_in_ready),
        .o_data  (conv_in_term)
    );

    bin_to_bcd u_bin_to_bcd (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (conv_in_valid),
        .o_ready (conv_in_ready),
        .i_term  (conv_in_term),
        .o_valid (conv_out_valid),
        .i_ready (conv_out_ready),
        .o_word  (conv_out_word)
    );

    stream_skid #(.T(bcd_word_t)) u_skid_word (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (conv_out_valid),
        .o_ready (conv_out_ready),
        .i_data  (conv_out_word),
        .o_valid (ser_valid),
        .i_ready (ser_ready),
        .o_data  (ser_word)
    );

    bcd_char_serializer #(.SUPPRESS_ZEROS(SUPPRESS_ZEROS)) u_serializer (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (ser_valid),
        .o_ready (ser_ready),
        .i_word  (ser_word),
        .o_valid (o_char_valid),
        .i_ready (i_char_ready),
        .o_beat  (o_char)
    );

endmodule

//--- hw/fib_pkg.sv
// Fibonacci display shared definitions
// widths, the supported index range and the payload structs that travel
// between the sequencer, the BCD converter and the character serializer

package fib_pkg;

    // term index from 0 to 20
    localparam int FIB_INDEX_W   = 5;
    localparam int FIB_MAX_INDEX = 20;

    // F(20) = 6765, and the recurrence briefly holds F(21) = 10946
    localparam int FIB_VALUE_W   = 14;

    localparam int FIB_TAG_W     = 4;
    localparam int BCD_DIGITS    = 4;

    // host request
    typedef struct packed {
        logic [FIB_TAG_W-1:0]   tag;
        logic [FIB_INDEX_W-1:0] index;
    } fib_req_t;

    // binary term from the sequencer
    typedef struct packed {
        logic [FIB_TAG_W-1:0]   tag;
        logic [FIB_VALUE_W-1:0] value;
    } fib_term_t;

    // digits[BCD_DIGITS-1] is the thousands digit
    typedef struct packed {
        logic [FIB_TAG_W-1:0]             tag;
        logic [BCD_DIGITS-1:0][3:0]       digits;
    } bcd_word_t;

    // one ASCII character on the output stream
    typedef struct packed {
        logic [FIB_TAG_W-1:0] tag;
        logic [7:0]           ascii;
        logic                 last;
    } char_beat_t;

endpackage

//--- hw/fib_sequencer.sv
// Fibonacci sequencer
// accepts a tagged index request and iterates the recurrence one addition
// per cycle, then holds the term until the next stage takes it

`timescale 1ns/10ps

module fib_sequencer
(
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_req_valid,
    output logic               o_req_ready,
    input  fib_pkg::fib_req_t  i_req,
    output logic               o_term_valid,
    input  logic               i_term_ready,
    output fib_pkg::fib_term_t o_term
);
    import fib_pkg::*;

    typedef enum logic [1:0] {e_idle, e_iterate, e_hold} t_state;

    t_state                 r_state;
    logic [FIB_INDEX_W-1:0] r_count;
    logic [FIB_VALUE_W-1:0] r_fib_a;
    logic [FIB_VALUE_W-1:0] r_fib_b;
    logic [FIB_TAG_W-1:0]   r_tag;
    logic                   w_accept;
    logic                   w_step;

    assign o_req_ready  = (r_state == e_idle);
    assign o_term_valid = (r_state == e_hold);
    assign w_accept     = i_req_valid & o_req_ready;
    // one addition while steps remain
    assign w_step       = (r_state == e_iterate) && (r_count != '0);

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_idle;
            r_count <= '0;
        end
        else
        begin
            case (r_state)
                e_idle:
                begin
                    if (w_accept)
                    begin
                        r_state <= e_iterate;
                        r_count <= i_req.index;
                    end
                end
                e_iterate:
                begin
                    if (r_count == '0)
                        r_state <= e_hold;
                    else
                        r_count <= r_count - 1'b1;
                end
                e_hold:
                begin
                    if (i_term_ready)
                        r_state <= e_idle;
                end
                default: r_state <= e_idle;
            endcase
        end
    end

    // a holds F(k), b holds F(k+1)
    always_ff @(posedge i_clk)
    begin
        if (w_accept)
        begin
            r_fib_a <= '0;
            r_fib_b <= FIB_VALUE_W'(1);
            r_tag   <= i_req.tag;
        end
        else if (w_step)
        begin
            r_fib_a <= r_fib_b;
            r_fib_b <= r_fib_a + r_fib_b;
        end
    end

    assign o_term.tag   = r_tag;
    assign o_term.value = r_fib_a;

endmodule

//--- hw/stream_skid.sv
// Valid/ready skid buffer
// two entries, a main register on the output and a spill register that
// catches one beat when the downstream side stalls, so o_ready is registered

`timescale 1ns/10ps

module stream_skid
#(
    parameter type T = fib_pkg::fib_term_t
)
(
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    logic r_main_valid;
    logic r_spill_valid;
    T     r_main;
    T     r_spill;
    logic w_in;
    logic w_main_free;

    // room while the spill entry is empty
    assign o_ready     = ~r_spill_valid;
    assign w_in        = i_valid & o_ready;
    assign w_main_free = ~r_main_valid | i_ready;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            r_main_valid  <= 1'b0;
            r_spill_valid <= 1'b0;
        end
        else if (w_main_free)
        begin
            // spill drains first to keep order
            r_main_valid  <= r_spill_valid | w_in;
            r_spill_valid <= 1'b0;
        end
        else if (w_in)
        begin
            r_spill_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_main_free)
            r_main <= r_spill_valid ? r_spill : i_data;
        else if (w_in)
            r_spill <= i_data;
    end

    assign o_valid = r_main_valid;
    assign o_data  = r_main;

endmodule

//--- tb/fib_display_sva.sv
// Protocol checks for the Fibonacci display pipeline
// output stability under back-pressure and idle levels around reset

`timescale 1ns/10ps

module fib_display_sva
(
    input logic                i_clk,
    input logic                i_rst,
    input logic                i_req_ready,
    input logic                i_char_valid,
    input logic                i_char_ready,
    input fib_pkg::char_beat_t i_char
);

    // idle levels while reset is held
    a_reset_levels: assert property (@(posedge i_clk)
        i_rst |-> (!i_char_valid && i_req_ready))
        else $error("output valid high or request ready low during reset");

    // and in the first cycle after release
    a_release_levels: assert property (@(posedge i_clk)
        $fell(i_rst) |-> (!i_char_valid && i_req_ready))
        else $error("output valid high or request ready low just after reset");

    // a stalled character beat keeps its valid and payload
    a_char_stall: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_char_valid && !i_char_ready) |=> (i_char_valid && $stable(i_char)))
        else $error("character beat changed or dropped while stalled");

endmodule

bind fib_display_top fib_display_sva u_sva (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_req_ready  (o_req_ready),
    .i_char_valid (o_char_valid),
    .i_char_ready (i_char_ready),
    .i_char       (o_char)
);

//--- tb/fib_display_tb.sv
// Testbench for the Fibonacci display pipeline
// index sweep then LFSR requests under random back-pressure, with a
// reference model feeding a queue of expected character beats

`timescale 1ns/10ps

module fib_display_tb
#(
    parameter bit SUPPRESS_ZEROS = 1'b1
)
();
    import fib_pkg::*;

    localparam int REQ_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 4000;
    localparam int RANDOM_REQS   = 40;

    logic       i_clk = 1'b0;
    logic       i_rst;
    logic       i_req_valid;
    logic       o_req_ready;
    fib_req_t   i_req;
    logic       o_char_valid;
    logic       i_char_ready;
    char_beat_t o_char;

    char_beat_t           exp_q[$];
    logic [15:0]          lfsr;
    logic [FIB_TAG_W-1:0] tag_count;
    logic                 timed_out;
    int                   value_errors;
    int                   proto_errors;
    int                   timeout_errors;
    int                   n_accepted;
    int                   n_last;
    int                   rnd;

    fib_display_top #(.SUPPRESS_ZEROS(SUPPRESS_ZEROS)) dut (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .i_req        (i_req),
        .o_char_valid (o_char_valid),
        .i_char_ready (i_char_ready),
        .o_char       (o_char)
    );

    always #50 i_clk = ~i_clk;

    // x^16 + x^15 + x^13 + x^4 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int k = 0; k < count; k++)
        begin
            lfsr = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic int fib_ref(input int n);
        int a;
        int b;
        int t;
        a = 0;
        b = 1;
        for (int k = 0; k < n; k++)
        begin
            t = a + b;
            a = b;
            b = t;
        end
        return a;
    endfunction

    // pos 0 is the thousands digit
    function automatic logic [7:0] digit_char(input int value, input int pos);
        int scale;
        scale = 1;
        for (int k = pos; k < BCD_DIGITS - 1; k++)
            scale = scale * 10;
        if (SUPPRESS_ZEROS && (pos < BCD_DIGITS - 1) && (value < scale))
            return 8'h20;
        else
            return 8'h30 + 8'((value / scale) % 10);
    endfunction

    task automatic push_expected(input fib_req_t req);
        char_beat_t beat;
        int         value;
        value = fib_ref(int'(req.index));
        beat.tag  = req.tag;
        beat.last = 1'b0;
        for (int p = 0; p < BCD_DIGITS; p++)
        begin
            beat.ascii = digit_char(value, p);
            exp_q.push_back(beat);
        end
        beat.ascii = 8'h0A;
        beat.last  = 1'b1;
        exp_q.push_back(beat);
        n_accepted++;
    endtask

    task automatic check_beat();
        char_beat_t expected;
        assert (exp_q.size() != 0)
        else
        begin
            proto_errors++;
            $display("character beat with tag %h arrived with no result outstanding",
                     o_char.tag);
        end
        if (exp_q.size() != 0)
        begin
            expected = exp_q.pop_front();
            assert (o_char == expected)
            else
            begin
                value_errors++;
                $display("FAIL o_char tag=%h ascii=%h last=%h expected tag=%h ascii=%h last=%h",
                         o_char.tag, o_char.ascii, o_char.last,
                         expected.tag, expected.ascii, expected.last);
            end
        end
        if (o_char.last)
            n_last++;
    endtask

    // inputs only change 5 ns after the rising edge, so the falling edge
    // sees the values that the next rising edge transfers
    always @(negedge i_clk)
    begin
        if (!i_rst)
        begin
            if (i_req_valid && o_req_ready)
                push_expected(i_req);
            if (o_char_valid && i_char_ready)
                check_beat();
        end
    end

    // one bit per cycle for the output ready
    task automatic next_cycle();
        int ready_bit;
        @(posedge i_clk);
        #5;
        take_bits(1, ready_bit);
        i_char_ready = ready_bit[0];
    endtask

    task automatic send_req(input int index);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        if (!timed_out)
        begin
            i_req.tag   = tag_count;
            i_req.index = FIB_INDEX_W'(index);
            i_req_valid = 1'b1;
            while (!accepted && !timed_out)
            begin
                @(negedge i_clk);
                accepted = o_req_ready;
                next_cycle();
                waited++;
                if (!accepted && waited >= REQ_TIMEOUT)
                begin
                    $display("timeout: request with tag %0d was never accepted", tag_count);
                    timeout_errors++;
                    timed_out = 1'b1;
                end
            end
            i_req_valid = 1'b0;
            tag_count   = tag_count + 1'b1;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !timed_out)
        begin
            next_cycle();
            waited++;
            if (waited >= DRAIN_TIMEOUT)
            begin
                $display("timeout: %0d expected beats never came out", exp_q.size());
                timeout_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    initial
    begin
        i_rst          = 1'b1;
        i_req_valid    = 1'b0;
        i_req          = '0;
        i_char_ready   = 1'b0;
        lfsr           = 16'd15;
        tag_count      = '0;
        timed_out      = 1'b0;
        value_errors   = 0;
        proto_errors   = 0;
        timeout_errors = 0;
        n_accepted     = 0;
        n_last         = 0;
        repeat (10) @(posedge i_clk);
        #5;
        i_rst = 1'b0;

        // every index once back to back
        for (int n = 0; n <= FIB_MAX_INDEX; n++)
            send_req(n);
        for (int k = 0; k < RANDOM_REQS; k++)
        begin
            take_bits(5, rnd);
            send_req(rnd % (FIB_MAX_INDEX + 1));
        end
        wait_drain();
        // a few idle cycles to catch stray beats
        for (int k = 0; k < 20; k++)
            next_cycle();

        assert (n_last == n_accepted)
        else
        begin
            proto_errors++;
            $display("%0d last beats seen for %0d accepted requests", n_last, n_accepted);
        end
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, proto_errors, timeout_errors);
        if (value_errors + proto_errors + timeout_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- verilog.f
hw/fib_pkg.sv
hw/fib_sequencer.sv
hw/stream_skid.sv
hw/bin_to_bcd.sv
hw/bcd_char_serializer.sv
hw/fib_display_top.sv
tb/fib_display_sva.sv
tb/fib_display_tb.sv
